// ==== hw/mengine_isa_pkg.sv ====
/*
 * mEngine instruction set.
 * Opcode encodings and the bit positions of each field in an instruction word.
 */
package mengine_isa_pkg;

    localparam int INSTR_WIDTH = 32;

    localparam int OPC_MSB = 31;          // Opcode sits in the top nibble.
    localparam int OPC_LSB = 28;

    localparam int IMM_MSB = 27;          // 13-bit immediate, zero-extended by LDI.
    localparam int IMM_LSB = 15;

    localparam int TGT_LSB = 15;          // JMP target, ADDR_WIDTH bits from here up.

    // Register fields live in the low 15 bits: src_a, src_b, dest.
    localparam int REG_FIELD_WIDTH = 5;
    localparam int SRCA_LSB        = 10;
    localparam int SRCB_LSB        = 5;
    localparam int DEST_LSB        = 0;

    typedef enum logic [3:0] {
        NOP    = 4'h0,
        LDI    = 4'h1,
        ADD    = 4'h2,
        SUB    = 4'h3,
        AND_OP = 4'h4,
        OR_OP  = 4'h5,
        XOR_OP = 4'h6,
        JMP    = 4'h7,                    // Consumed by fetch.
        HALT   = 4'h8                     // Consumed by fetch.
    } opcode_t;

endpackage

// ==== hw/mengine_cfg_pkg.sv ====
/*
 * mEngine microarchitecture configuration.
 * Widths, queue and register file depths, and the program image.
 */
package mengine_cfg_pkg;

    localparam int ADDR_WIDTH = 6;        // 64 ROM words.
    localparam int DATA_WIDTH = 32;
    localparam int RF_DEPTH   = 32;

    localparam int IBUF_DEPTH     = 4;    // Must stay a power of two.
    localparam int IBUF_PTR_WIDTH = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_WIDTH = $clog2(IBUF_DEPTH + 1);

    localparam string ROM_FILE = "program.hex";

endpackage

// ==== hw/mengine_fetch.sv ====
`timescale 1ns/1ps
/*
 * mEngine fetch unit.
 * Holds the PC and program ROM, resolves JMP and HALT locally and
 * offers every other word to the buffer over a four-phase handshake.
 */
module mengine_fetch (
    input  logic                                    clock,
    input  logic                                    reset_,
    input  logic                                    fetch_ack,
    output logic                                    fetch_req,
    output logic [mengine_isa_pkg::INSTR_WIDTH-1:0] fetch_instr,
    output logic [mengine_cfg_pkg::ADDR_WIDTH-1:0]  fetch_pc
);
    import mengine_isa_pkg::*;
    import mengine_cfg_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP, HALTED} state_t;

    state_t                 state;
    logic [ADDR_WIDTH-1:0]  pc;
    logic [INSTR_WIDTH-1:0] rom [0:(2**ADDR_WIDTH)-1];
    logic [INSTR_WIDTH-1:0] rom_word;
    opcode_t                opcode;

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    assign rom_word = rom[pc];                               // Asynchronous ROM read.
    assign opcode   = opcode_t'(rom_word[OPC_MSB:OPC_LSB]);  // Predecode.

    always_ff @(posedge clock or negedge reset_) begin
        if (!reset_) begin
            state     <= IDLE;
            pc        <= '0;
            fetch_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (opcode == JMP) begin
                        pc <= rom_word[TGT_LSB +: ADDR_WIDTH];  // Taken in one cycle.
                    end else if (opcode == HALT) begin
                        state <= HALTED;                        // PC stays frozen.
                    end else begin
                        fetch_req <= 1'b1;
                        state     <= REQ;
                    end
                end
                REQ: begin
                    if (fetch_ack) begin                        // Buffer has stored the word.
                        fetch_req <= 1'b0;
                        pc        <= pc + 1'b1;
                        state     <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    if (!fetch_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= HALTED;                       // Only reset leaves HALTED.
            endcase
        end
    end

    // The offered word is captured while idle and held for the whole request.
    always_ff @(posedge clock) begin
        if (state == IDLE) begin
            fetch_instr <= rom_word;
            fetch_pc    <= pc;
        end
    end

    // Request may only be withdrawn once the buffer has answered.
    a_req_until_ack: assert property (@(posedge clock) disable iff (!reset_)
        $fell(fetch_req) |-> $past(fetch_ack))
        else $error("fetch_req dropped before fetch_ack rose");

endmodule

// ==== hw/mengine_ibuf.sv ====
`timescale 1ns/1ps
/*
 * mEngine instruction buffer.
 * Circular queue of instruction/PC pairs between fetch and exec, with a
 * four-phase receiver on the input and an independent sender on the output.
 */
module mengine_ibuf (
    input  logic                                    clock,
    input  logic                                    reset_,
    input  logic                                    fetch_req,
    input  logic [mengine_isa_pkg::INSTR_WIDTH-1:0] fetch_instr,
    input  logic [mengine_cfg_pkg::ADDR_WIDTH-1:0]  fetch_pc,
    input  logic                                    issue_ack,
    output logic                                    fetch_ack,
    output logic                                    issue_req,
    output logic [mengine_isa_pkg::INSTR_WIDTH-1:0] issue_instr,
    output logic [mengine_cfg_pkg::ADDR_WIDTH-1:0]  issue_pc
);
    import mengine_isa_pkg::*;
    import mengine_cfg_pkg::*;

    typedef enum logic {R_IDLE, R_ACK} rx_state_t;
    typedef enum logic [1:0] {S_IDLE, S_REQ, S_DROP} tx_state_t;

    rx_state_t                 rx_state;
    tx_state_t                 tx_state;
    logic [INSTR_WIDTH-1:0]    instr_mem [0:IBUF_DEPTH-1];
    logic [ADDR_WIDTH-1:0]     pc_mem [0:IBUF_DEPTH-1];
    logic [IBUF_PTR_WIDTH-1:0] wr_ptr;
    logic [IBUF_PTR_WIDTH-1:0] rd_ptr;
    logic [IBUF_CNT_WIDTH-1:0] count;
    logic                      push;
    logic                      pop;

    // A full queue withholds ack, which stalls fetch.
    assign push = (rx_state == R_IDLE) && fetch_req && (count < IBUF_CNT_WIDTH'(IBUF_DEPTH));
    assign pop  = (tx_state == S_REQ) && issue_ack;    // Entry leaves as exec acks.

    assign fetch_ack   = (rx_state == R_ACK);
    assign issue_req   = (tx_state == S_REQ);
    assign issue_instr = instr_mem[rd_ptr];
    assign issue_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clock or negedge reset_) begin
        if (!reset_) begin
            rx_state <= R_IDLE;
        end else if (rx_state == R_IDLE) begin
            if (push) begin
                rx_state <= R_ACK;
            end
        end else if (!fetch_req) begin
            rx_state <= R_IDLE;                        // Return to zero.
        end
    end

    always_ff @(posedge clock or negedge reset_) begin
        if (!reset_) begin
            tx_state <= S_IDLE;
        end else begin
            case (tx_state)
                S_IDLE:  if (count != '0) tx_state <= S_REQ;
                S_REQ:   if (issue_ack) tx_state <= S_DROP;
                default: if (!issue_ack) tx_state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + IBUF_PTR_WIDTH'(push);  // Pointers wrap at the depth.
            rd_ptr <= rd_ptr + IBUF_PTR_WIDTH'(pop);
            count  <= count + IBUF_CNT_WIDTH'(push) - IBUF_CNT_WIDTH'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            instr_mem[wr_ptr] <= fetch_instr;
            pc_mem[wr_ptr]    <= fetch_pc;
        end
    end

    a_count_bound: assert property (@(posedge clock) disable iff (!reset_)
        count <= IBUF_CNT_WIDTH'(IBUF_DEPTH))
        else $error("instruction buffer count above depth");

    // A pending issue must not change under exec before it is acknowledged.
    a_issue_stable: assert property (@(posedge clock) disable iff (!reset_)
        issue_req && !issue_ack |=> $stable(issue_instr) && $stable(issue_pc))
        else $error("issue data changed while issue_req was pending");

endmodule

// ==== hw/mengine_exec.sv ====
`timescale 1ns/1ps
/*
 * mEngine execute unit.
 * Accepts one instruction at a time, reads the register file, runs the
 * ALU, writes the result back and reports each instruction on retire.
 */
module mengine_exec (
    input  logic                                        clock,
    input  logic                                        reset_,
    input  logic                                        issue_req,
    input  logic [mengine_isa_pkg::INSTR_WIDTH-1:0]     issue_instr,
    input  logic [mengine_cfg_pkg::ADDR_WIDTH-1:0]      issue_pc,
    output logic                                        issue_ack,
    output logic                                        retire_valid,
    output logic [mengine_cfg_pkg::ADDR_WIDTH-1:0]      retire_pc,
    output logic                                        retire_we,
    output logic [mengine_isa_pkg::REG_FIELD_WIDTH-1:0] retire_dest,
    output logic [mengine_cfg_pkg::DATA_WIDTH-1:0]      retire_data
);
    import mengine_isa_pkg::*;
    import mengine_cfg_pkg::*;

    typedef enum logic [1:0] {E_IDLE, E_EXEC, E_WB} state_t;

    state_t                     state;
    logic                       accept;
    logic                       we;
    logic [INSTR_WIDTH-1:0]     ir;
    logic [ADDR_WIDTH-1:0]      ir_pc;
    logic [DATA_WIDTH-1:0]      rf [0:RF_DEPTH-1];
    logic [REG_FIELD_WIDTH-1:0] src_a;
    logic [REG_FIELD_WIDTH-1:0] src_b;
    logic [REG_FIELD_WIDTH-1:0] dest;
    logic [DATA_WIDTH-1:0]      opr_a;
    logic [DATA_WIDTH-1:0]      opr_b;
    logic [DATA_WIDTH-1:0]      alu_out;
    logic [DATA_WIDTH-1:0]      wr_data;
    opcode_t                    opcode;

    assign accept = (state == E_IDLE) && issue_req && !issue_ack;

    assign opcode = opcode_t'(ir[OPC_MSB:OPC_LSB]);
    assign src_a  = ir[SRCA_LSB +: REG_FIELD_WIDTH];
    assign src_b  = ir[SRCB_LSB +: REG_FIELD_WIDTH];
    assign dest   = ir[DEST_LSB +: REG_FIELD_WIDTH];
    assign opr_a  = rf[src_a];
    assign opr_b  = rf[src_b];

    always_comb begin
        case (opcode)
            LDI:     alu_out = DATA_WIDTH'(ir[IMM_MSB:IMM_LSB]);
            ADD:     alu_out = opr_a + opr_b;
            SUB:     alu_out = opr_a - opr_b;      // Wraps modulo 2^32.
            AND_OP:  alu_out = opr_a & opr_b;
            OR_OP:   alu_out = opr_a | opr_b;
            XOR_OP:  alu_out = opr_a ^ opr_b;
            default: alu_out = '0;                 // NOP and unused codes.
        endcase
    end

    always_ff @(posedge clock or negedge reset_) begin
        if (!reset_) begin
            state     <= E_IDLE;
            issue_ack <= 1'b0;
            we        <= 1'b0;
        end else begin
            if (issue_ack && !issue_req) begin
                issue_ack <= 1'b0;
            end
            case (state)
                E_IDLE: begin
                    if (accept) begin
                        issue_ack <= 1'b1;
                        state     <= E_EXEC;
                    end
                end
                E_EXEC: begin
                    we    <= opcode inside {LDI, ADD, SUB, AND_OP, OR_OP, XOR_OP};
                    state <= E_WB;
                end
                default: state <= E_IDLE;          // Retire cycle is over.
            endcase
        end
    end

    // Instruction latch and ALU result register.
    always_ff @(posedge clock) begin
        if (accept) begin
            ir    <= issue_instr;
            ir_pc <= issue_pc;
        end
        if (state == E_EXEC) begin
            wr_data <= alu_out;
        end
    end

    always_ff @(posedge clock or negedge reset_) begin
        if (!reset_) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                rf[i] <= '0;
            end
        end else if (state == E_WB && we) begin
            rf[dest] <= wr_data;
        end
    end

    always_ff @(posedge clock or negedge reset_) begin
        if (!reset_) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= (state == E_WB);
            retire_we    <= (state == E_WB) && we;
        end
    end

    always_ff @(posedge clock) begin
        if (state == E_WB) begin
            retire_pc   <= ir_pc;
            retire_dest <= dest;
            retire_data <= wr_data;
        end
    end

    // Ack is withheld across the retire cycle, so retires never touch.
    a_retire_pulse: assert property (@(posedge clock) disable iff (!reset_)
        retire_valid |=> !retire_valid)
        else $error("retire_valid high on consecutive cycles");

endmodule

// ==== hw/mengine_top.sv ====
`timescale 1ns/1ps
/*
 * mEngine top level.
 * Chains fetch, the instruction buffer and exec; only retire leaves the core.
 */
module mengine_top (
    input  logic                                        clock,
    input  logic                                        reset_,
    output logic                                        retire_valid,
    output logic [mengine_cfg_pkg::ADDR_WIDTH-1:0]      retire_pc,
    output logic                                        retire_we,
    output logic [mengine_isa_pkg::REG_FIELD_WIDTH-1:0] retire_dest,
    output logic [mengine_cfg_pkg::DATA_WIDTH-1:0]      retire_data
);
    import mengine_isa_pkg::*;
    import mengine_cfg_pkg::*;

    // Fetch to buffer link.
    logic                   fetch_req;
    logic                   fetch_ack;
    logic [INSTR_WIDTH-1:0] fetch_instr;
    logic [ADDR_WIDTH-1:0]  fetch_pc;

    // Buffer to exec link.
    logic                   issue_req;
    logic                   issue_ack;
    logic [INSTR_WIDTH-1:0] issue_instr;
    logic [ADDR_WIDTH-1:0]  issue_pc;

    mengine_fetch u_fetch (.*);
    mengine_ibuf  u_ibuf  (.*);
    mengine_exec  u_exec  (.*);

endmodule

// ==== tb/tb_mengine.sv ====
`timescale 1ns/1ps
/*
 * mEngine testbench.
 * Walks the program image with a reference model and checks every retire
 * of the core against it, then watches for a quiet core after HALT.
 */
module tb_mengine;
    import mengine_isa_pkg::*;
    import mengine_cfg_pkg::*;

    localparam int CLOCK_PERIOD_NS = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_WORD = 16;   // Generous bound for one word through the core.
    localparam int QUIET_CYCLES    = 200;
    localparam int MAX_RETIRES     = 256;
    localparam int WATCHDOG_NS     = ((2**ADDR_WIDTH) * CYCLES_PER_WORD + RESET_CYCLES
                                      + QUIET_CYCLES) * CLOCK_PERIOD_NS;

    logic                       clock = 1'b0;
    logic                       reset_;
    logic                       retire_valid;
    logic [ADDR_WIDTH-1:0]      retire_pc;
    logic                       retire_we;
    logic [REG_FIELD_WIDTH-1:0] retire_dest;
    logic [DATA_WIDTH-1:0]      retire_data;

    logic [INSTR_WIDTH-1:0]     rom_image [0:(2**ADDR_WIDTH)-1];
    logic [DATA_WIDTH-1:0]      model_rf [0:RF_DEPTH-1];
    logic [ADDR_WIDTH-1:0]      exp_pc [0:MAX_RETIRES-1];
    logic                       exp_we [0:MAX_RETIRES-1];
    logic [REG_FIELD_WIDTH-1:0] exp_dest [0:MAX_RETIRES-1];
    logic [DATA_WIDTH-1:0]      exp_data [0:MAX_RETIRES-1];
    int                         exp_count = 0;
    int                         retire_idx = 0;
    int                         value_errors = 0;
    int                         other_errors = 0;

    mengine_top dut (.*);

    always #(CLOCK_PERIOD_NS / 2) clock = ~clock;

    task automatic report_mismatch(input string what, input logic [DATA_WIDTH-1:0] got,
                                   input logic [DATA_WIDTH-1:0] expected);
        value_errors++;
        $display("FAIL at %0t: %s on retire %0d, got 0x%0h, expected 0x%0h",
                 $time, what, retire_idx, got, expected);
    endtask

    task automatic note_failure(input string what);
        other_errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic print_summary();
        $display("Summary: %0d of %0d retires seen, %0d value errors, %0d other errors",
                 retire_idx, exp_count, value_errors, other_errors);
    endtask

    // Follows the program from PC 0 the way the ISA defines it.
    task automatic build_expected();
        logic [ADDR_WIDTH-1:0]  pc;
        logic [INSTR_WIDTH-1:0] word;
        logic [3:0]             opc;
        logic [DATA_WIDTH-1:0]  a;
        logic [DATA_WIDTH-1:0]  b;
        logic [DATA_WIDTH-1:0]  result;
        logic                   writes;
        int                     steps;
        pc    = '0;
        steps = 0;
        for (int i = 0; i < RF_DEPTH; i++) model_rf[i] = '0;
        while (steps < 4 * (2**ADDR_WIDTH) && exp_count < MAX_RETIRES) begin
            word   = rom_image[pc];
            opc    = word[OPC_MSB:OPC_LSB];
            a      = model_rf[word[SRCA_LSB +: REG_FIELD_WIDTH]];
            b      = model_rf[word[SRCB_LSB +: REG_FIELD_WIDTH]];
            writes = 1'b1;
            steps++;
            if (opc == HALT) break;
            if (opc == JMP) begin
                pc = word[TGT_LSB +: ADDR_WIDTH];     // Jumps never retire.
                continue;
            end
            case (opc)
                LDI:     result = DATA_WIDTH'(word[IMM_MSB:IMM_LSB]);
                ADD:     result = a + b;
                SUB:     result = a - b;
                AND_OP:  result = a & b;
                OR_OP:   result = a | b;
                XOR_OP:  result = a ^ b;
                default: begin
                    result = '0;
                    writes = 1'b0;
                end
            endcase
            exp_pc[exp_count]   = pc;
            exp_we[exp_count]   = writes;
            exp_dest[exp_count] = word[DEST_LSB +: REG_FIELD_WIDTH];
            exp_data[exp_count] = result;
            if (writes) model_rf[word[DEST_LSB +: REG_FIELD_WIDTH]] = result;
            exp_count++;
            pc = pc + 1'b1;
        end
    endtask

    // Retire outputs settle after the rising edge, so they are checked on the falling one.
    always @(posedge clock) begin
        if (reset_ && retire_valid) retire_idx <= retire_idx + 1;
    end

    a_quiet_in_reset: assert property (@(negedge clock) !reset_ |-> !retire_valid && !retire_we)
        else note_failure("retire outputs were active while reset was asserted");
    a_we_needs_valid: assert property (@(negedge clock) disable iff (!reset_)
        !retire_valid |-> !retire_we)
        else note_failure("retire_we was high without a retire");
    a_no_extra_retire: assert property (@(negedge clock) disable iff (!reset_)
        retire_valid |-> retire_idx < exp_count)
        else note_failure("an instruction retired beyond the end of the program");
    a_first_pc: assert property (@(negedge clock) disable iff (!reset_)
        retire_valid && retire_idx == 0 |-> retire_pc == '0)
        else report_mismatch("first retire pc", DATA_WIDTH'(retire_pc), '0);
    a_retire_pc: assert property (@(negedge clock) disable iff (!reset_)
        retire_valid && retire_idx < exp_count |-> retire_pc == exp_pc[retire_idx])
        else report_mismatch("retire pc", DATA_WIDTH'(retire_pc),
                             DATA_WIDTH'(exp_pc[retire_idx]));
    a_retire_we: assert property (@(negedge clock) disable iff (!reset_)
        retire_valid && retire_idx < exp_count |-> retire_we == exp_we[retire_idx])
        else report_mismatch("retire we", DATA_WIDTH'(retire_we),
                             DATA_WIDTH'(exp_we[retire_idx]));
    a_retire_dest: assert property (@(negedge clock) disable iff (!reset_)
        retire_valid && retire_idx < exp_count && exp_we[retire_idx]
        |-> retire_dest == exp_dest[retire_idx])
        else report_mismatch("retire dest", DATA_WIDTH'(retire_dest),
                             DATA_WIDTH'(exp_dest[retire_idx]));
    a_retire_data: assert property (@(negedge clock) disable iff (!reset_)
        retire_valid && retire_idx < exp_count && exp_we[retire_idx]
        |-> retire_data == exp_data[retire_idx])
        else report_mismatch("retire data", retire_data, exp_data[retire_idx]);

    initial begin
        reset_ = 1'b0;
        $readmemh(ROM_FILE, rom_image);
        build_expected();
        a_model_sane: assert (exp_count > 0)
            else note_failure("the reference model found no instruction to retire");
        @(posedge clock);
        reset_ <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_ <= 1'b1;
        wait (retire_idx == exp_count);
        repeat (QUIET_CYCLES) @(posedge clock);   // Nothing may retire after HALT.
        a_retire_total: assert (retire_idx == exp_count)
            else note_failure("the number of retires after HALT differs from the model");
        print_summary();
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the program did not retire all its instructions in %0d ns",
                 WATCHDOG_NS);
        print_summary();
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== program.hex ====
// mEngine program image, 64 words of 8 hex digits, four per line from address 00.
// Word fields: opcode[31:28] imm or target[27:15] src_a[14:10] src_b[9:5] dest[4:0].
1FFF8001 10918002 20000443 30000824  // 00: LDI r1, LDI r2, ADD r3, SUB r4
40000465 50001046 60001827 00000000  // 04: AND r5, OR r6, XOR r7, NOP
700A0000 1AAA801F 1AAA801F 1AAA801F  // 08: JMP 20, skipped words
1AAA801F 1AAA801F 1AAA801F 1AAA801F
1AAA801F 1AAA801F 1AAA801F 1AAA801F
10038008 30000109 2000252A 6000286B  // 20: LDI r8, SUB r9, ADD r10, XOR r11
00000000 70140000 1AAA801F 1AAA801F  // 24: NOP, JMP 40, skipped words
1AAA801F 1AAA801F 1AAA801F 1AAA801F
1AAA801F 1AAA801F 1AAA801F 1AAA801F
1AAA801F 1AAA801F 1AAA801F 1AAA801F
50002CAC 400030ED 15550001 200005AE  // 40: OR r12, AND r13, LDI r1, ADD r14
80000000 1AAA801F 1AAA801F 1AAA801F  // 44: HALT, unreachable words
1AAA801F 1AAA801F 1AAA801F 1AAA801F
1AAA801F 1AAA801F 1AAA801F 1AAA801F
1AAA801F 1AAA801F 1AAA801F 1AAA801F
1AAA801F 1AAA801F 1AAA801F 1AAA801F

// ==== sim.f ====
hw/mengine_isa_pkg.sv
hw/mengine_cfg_pkg.sv
hw/mengine_fetch.sv
hw/mengine_ibuf.sv
hw/mengine_exec.sv
hw/mengine_top.sv
tb/tb_mengine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the mEngine testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mengine -f sim.f \
    -o tb_mengine > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_mengine > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
